//--- design/core_pkg.sv
package core_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  plv_t;

    // [15] valid, [14:6] esubcode, [5:0] ecode
    typedef logic [15:0] excp_t;

    localparam logic [5:0] ECODE_ADEF = 6'h08;   // Fetch address error

    localparam addr_t RESET_PC = 32'h1c00_0000;

endpackage

//--- design/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

    // Fetch buffer
    localparam int FB_DEPTH = 16;
    localparam int FB_PTR_W = 5;                  // Count runs 0..FB_DEPTH
    localparam int FB_IDX_W = $clog2(FB_DEPTH);

    // Word at byte address a of instruction memory holds a ^ MEM_FILL
    localparam int          MEM_BYTES = 4096;
    localparam int          MEM_WORDS = MEM_BYTES / 4;
    localparam int          MEM_IDX_W = $clog2(MEM_WORDS);
    localparam logic [31:0] MEM_FILL  = 32'h3c5a_96e1;

    // Cycles from req rising to ack rising
    localparam int MEM_LAT_MIN = 1;
    localparam int MEM_LAT_MAX = 4;

endpackage

//--- design/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen import core_pkg::*, fetch_cfg_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        redirect,
    input  addr_t       redirect_pc,
    input  plv_t        plv,
    input  logic        fb_stall,
    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_ack,
    input  logic [63:0] mem_rdata,
    output logic        push,
    output logic        push_two,
    output inst_t       push_ir0,
    output inst_t       push_ir1,
    output addr_t       push_pc,
    output plv_t        push_plv,
    output excp_t       push_excp
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_REL,
        S_HALT,
        S_FAULT
    } state_t;

    state_t state;
    addr_t  pc;
    addr_t  pc_aligned;
    addr_t  tgt_offs;
    plv_t   fetch_plv;
    logic   stale;      // Handshake still open for a request dropped by redirect
    logic   tgt_ok;
    logic   issue;

    assign pc_aligned = {pc[31:3], 3'b000};
    assign tgt_offs   = redirect_pc - RESET_PC;
    assign tgt_ok     = (redirect_pc[1:0] == 2'b00) && (tgt_offs < addr_t'(MEM_BYTES));
    assign issue      = !redirect && (state == S_IDLE) && !stale && !fb_stall;

    // Pair comes back on ack; a pc with bit 2 set keeps only the upper word
    assign push      = !redirect && (((state == S_REQ) && mem_ack) || (state == S_FAULT));
    assign push_two  = (state == S_REQ) && !pc[2];
    assign push_ir0  = (state == S_FAULT) ? '0 :
                       (pc[2] ? mem_rdata[63:32] : mem_rdata[31:0]);
    assign push_ir1  = mem_rdata[63:32];
    assign push_pc   = pc;
    assign push_plv  = fetch_plv;
    assign push_excp = (state == S_FAULT) ? {1'b1, 9'd0, ECODE_ADEF} : '0;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state   <= S_IDLE;
            pc      <= RESET_PC;
            stale   <= 1'b0;
            mem_req <= 1'b0;
        end
        else
        begin
            if (mem_req && mem_ack)
                mem_req <= 1'b0;
            if (stale && !mem_req && !mem_ack)
                stale <= 1'b0;          // Orphan handshake has closed

            if (redirect)
            begin
                pc    <= redirect_pc;
                state <= tgt_ok ? S_IDLE : S_FAULT;
                if ((state == S_REQ) || (state == S_REL))
                    stale <= 1'b1;
            end
            else
            begin
                case (state)
                    S_IDLE:
                        if (issue)
                        begin
                            mem_req <= 1'b1;
                            state   <= S_REQ;
                        end
                    S_REQ:
                        if (mem_ack)
                        begin
                            pc    <= pc_aligned + 32'd8;
                            state <= S_REL;
                        end
                    S_REL:
                        if (!mem_ack)
                            state <= S_IDLE;
                    S_FAULT:
                        state <= S_HALT;
                    default: ;                  // Halted until the next redirect
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (redirect)
            fetch_plv <= plv;   // Stamp for a possible fault entry
        else if (issue)
        begin
            mem_addr  <= pc_aligned;
            fetch_plv <= plv;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        mem_req |=> (!mem_req || $stable(mem_addr)))
        else $error("fetch_pc_gen: mem_addr changed during request");

    // Room is checked at issue and can only grow until the data returns
    assert property (@(posedge clk) disable iff (!rstn)
        push |-> !fb_stall)
        else $error("fetch_pc_gen: push while buffer stalled");

endmodule

//--- design/inst_mem.sv
`timescale 1ns/1ps

module inst_mem import core_pkg::*, fetch_cfg_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        mem_req,
    input  addr_t       mem_addr,
    output logic        mem_ack,
    output logic [63:0] mem_rdata
);

    inst_t mem [MEM_WORDS];

    logic [3:0]           lfsr;
    logic [2:0]           lat;
    logic [2:0]           cnt;
    logic                 busy;
    logic                 req_new;
    logic                 ack_set;
    addr_t                offs;
    logic [MEM_IDX_W-1:0] widx_lo;
    logic [MEM_IDX_W-1:0] widx_hi;

    assign lat = 3'(MEM_LAT_MIN + int'(lfsr) % (MEM_LAT_MAX - MEM_LAT_MIN + 1));

    assign offs    = mem_addr - RESET_PC;
    assign widx_lo = {offs[MEM_IDX_W+1:3], 1'b0};
    assign widx_hi = {offs[MEM_IDX_W+1:3], 1'b1};

    // A fresh request is one seen after the previous ack has fallen
    assign req_new = mem_req && !mem_ack && !busy;
    assign ack_set = (busy && (cnt == 3'd1)) || (req_new && (lat == 3'd1));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= (RESET_PC + addr_t'(i * 4)) ^ MEM_FILL;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            lfsr    <= 4'b1001;
            cnt     <= '0;
            busy    <= 1'b0;
            mem_ack <= 1'b0;
        end
        else
        begin
            if (ack_set)
            begin
                mem_ack <= 1'b1;
                busy    <= 1'b0;
            end
            else if (mem_ack && !mem_req)
                mem_ack <= 1'b0;       // Release phase
            else if (busy)
                cnt <= cnt - 3'd1;
            else if (req_new)
            begin
                busy <= 1'b1;
                cnt  <= lat - 3'd1;
            end

            if (req_new)
                lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};   // x^4 + x^3 + 1
        end
    end

    always_ff @(posedge clk)
    begin
        if (ack_set)
            mem_rdata <= {mem[widx_hi], mem[widx_lo]};
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (!mem_req && !mem_ack) |=> !mem_ack)
        else $error("inst_mem: ack without request");

endmodule

//--- design/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer import core_pkg::*, fetch_cfg_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  flush,
    input  logic  push,
    input  logic  push_two,
    input  inst_t push_ir0,
    input  inst_t push_ir1,
    input  addr_t push_pc,
    input  plv_t  push_plv,
    input  excp_t push_excp,
    input  logic  pop0,
    input  logic  pop1,
    output logic  fb_stall,
    output logic  valid0,
    output logic  valid1,
    output inst_t ir0,
    output inst_t ir1,
    output addr_t pc0,
    output addr_t pc1,
    output plv_t  plv0,
    output plv_t  plv1,
    output excp_t excp0,
    output excp_t excp1
);

    inst_t ir_q   [FB_DEPTH];
    addr_t pc_q   [FB_DEPTH];
    plv_t  plv_q  [FB_DEPTH];
    excp_t excp_q [FB_DEPTH];

    logic [FB_IDX_W-1:0] head;      // Oldest entry
    logic [FB_IDX_W-1:0] tail;      // Next free slot
    logic [FB_IDX_W-1:0] head_nx;
    logic [FB_IDX_W-1:0] tail_nx;
    logic [FB_PTR_W-1:0] count;
    logic [FB_PTR_W-1:0] free;
    logic [1:0]          n_push;
    logic [1:0]          n_pop;

    assign head_nx = head + 1'b1;
    assign tail_nx = tail + 1'b1;
    assign free    = FB_PTR_W'(FB_DEPTH) - count;

    assign n_push = push ? (push_two ? 2'd2 : 2'd1) : 2'd0;
    // pop1 only counts together with pop0
    assign n_pop  = (pop0 && valid0) ? ((pop1 && valid1) ? 2'd2 : 2'd1) : 2'd0;

    assign fb_stall = free < FB_PTR_W'(2);
    assign valid0   = count != '0;
    assign valid1   = count > FB_PTR_W'(1);

    assign ir0   = ir_q[head];
    assign ir1   = ir_q[head_nx];
    assign pc0   = pc_q[head];
    assign pc1   = pc_q[head_nx];
    assign plv0  = plv_q[head];
    assign plv1  = plv_q[head_nx];
    assign excp0 = excp_q[head];
    assign excp1 = excp_q[head_nx];

    always_ff @(posedge clk)
    begin
        if (push && !flush)
        begin
            ir_q[tail]   <= push_ir0;
            pc_q[tail]   <= push_pc;
            plv_q[tail]  <= push_plv;
            excp_q[tail] <= push_excp;
            if (push_two)
            begin
                ir_q[tail_nx]   <= push_ir1;
                pc_q[tail_nx]   <= push_pc + 32'd4;
                plv_q[tail_nx]  <= push_plv;
                excp_q[tail_nx] <= '0;      // Upper word never carries a fault
            end
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else if (flush)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else
        begin
            head  <= head + FB_IDX_W'(n_pop);
            tail  <= tail + FB_IDX_W'(n_push);
            count <= count + FB_PTR_W'(n_push) - FB_PTR_W'(n_pop);
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        pop1 |-> pop0)
        else $error("fetch_buffer: pop1 without pop0");

    assert property (@(posedge clk) disable iff (!rstn)
        (!pop0 || valid0) && (!pop1 || valid1))
        else $error("fetch_buffer: pop of an empty slot");

    assert property (@(posedge clk) disable iff (!rstn)
        push |-> (FB_PTR_W'(n_push) <= free))
        else $error("fetch_buffer: overflow");

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import core_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  plv_t  plv,
    input  logic  pop0,
    input  logic  pop1,
    output logic  valid0,
    output logic  valid1,
    output inst_t ir0,
    output inst_t ir1,
    output addr_t pc0,
    output addr_t pc1,
    output plv_t  plv0,
    output plv_t  plv1,
    output excp_t excp0,
    output excp_t excp1
);

    // Memory port
    logic        mem_req;
    addr_t       mem_addr;
    logic        mem_ack;
    logic [63:0] mem_rdata;

    // Enqueue side of the buffer
    logic  push;
    logic  push_two;
    inst_t push_ir0;
    inst_t push_ir1;
    addr_t push_pc;
    plv_t  push_plv;
    excp_t push_excp;
    logic  fb_stall;

    fetch_pc_gen u_pc_gen (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .plv         (plv),
        .fb_stall    (fb_stall),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .push        (push),
        .push_two    (push_two),
        .push_ir0    (push_ir0),
        .push_ir1    (push_ir1),
        .push_pc     (push_pc),
        .push_plv    (push_plv),
        .push_excp   (push_excp)
    );

    inst_mem u_inst_mem (
        .clk       (clk),
        .rstn      (rstn),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    fetch_buffer u_fetch_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (redirect),      // Redirect empties the queue
        .push      (push),
        .push_two  (push_two),
        .push_ir0  (push_ir0),
        .push_ir1  (push_ir1),
        .push_pc   (push_pc),
        .push_plv  (push_plv),
        .push_excp (push_excp),
        .pop0      (pop0),
        .pop1      (pop1),
        .fb_stall  (fb_stall),
        .valid0    (valid0),
        .valid1    (valid1),
        .ir0       (ir0),
        .ir1       (ir1),
        .pc0       (pc0),
        .pc1       (pc1),
        .plv0      (plv0),
        .plv1      (plv1),
        .excp0     (excp0),
        .excp1     (excp1)
    );

endmodule

//--- tb/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top import core_pkg::*, fetch_cfg_pkg::*; ();

    localparam int    SEED        = 48081;
    localparam int    N_TESTS     = 6;
    localparam int    TEST_CYCLES = 200;    // Upper bound on the cycles one test takes
    localparam int    POP_NONE    = 0;
    localparam int    POP_RANDOM  = 1;
    localparam int    POP_ALL     = 2;
    localparam excp_t ADEF_EXCP   = {1'b1, 9'd0, ECODE_ADEF};

    logic  clk;
    logic  rstn;
    logic  redirect;
    addr_t redirect_pc;
    plv_t  plv;
    logic  pop0;
    logic  pop1;
    logic  valid0;
    logic  valid1;
    inst_t ir0;
    inst_t ir1;
    addr_t pc0;
    addr_t pc1;
    plv_t  plv0;
    plv_t  plv1;
    excp_t excp0;
    excp_t excp1;

    // Reference model
    addr_t exp_pc;          // pc of the next entry decode should see
    plv_t  exp_plv;
    logic  fault_pending;   // Next entry is the address fault
    logic  halted;          // Fault entry taken, nothing more until redirect

    int err_cnt;
    int pop_cnt;
    int tests_passed;
    int tests_failed;

    fetch_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        repeat (N_TESTS * TEST_CYCLES + 100) @(posedge clk);
        $display("Watchdog timeout, run exceeded %0d cycles", N_TESTS * TEST_CYCLES + 100);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic compare_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic compare_plv(input string name, input plv_t got, input plv_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic compare_excp(input string name, input excp_t got, input excp_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // One entry taken by decode, checked against the model
    task automatic score_entry(input int slot, input inst_t ir, input addr_t pc,
                               input plv_t pl, input excp_t ex);
        compare_addr($sformatf("pc%0d", slot), pc, exp_pc);
        compare_plv($sformatf("plv%0d", slot), pl, exp_plv);
        if (fault_pending)
        begin
            compare_inst($sformatf("ir%0d", slot), ir, '0);
            compare_excp($sformatf("excp%0d", slot), ex, ADEF_EXCP);
            fault_pending = 1'b0;
            halted        = 1'b1;
        end
        else
        begin
            compare_inst($sformatf("ir%0d", slot), ir, exp_pc ^ MEM_FILL);
            compare_excp($sformatf("excp%0d", slot), ex, '0);
            exp_pc = exp_pc + 32'd4;
        end
        pop_cnt++;
    endtask

    task automatic run_cycle(input int mode);
        int r;
        @(posedge clk);
        #2;
        r    = $urandom % 4;
        pop0 = 1'b0;
        pop1 = 1'b0;
        if (valid1 && !valid0)
        begin
            $display("[ERROR] valid1 got 1 expected 0 with valid0 low at %0t", $time);
            err_cnt++;
        end
        if (halted && valid0)
        begin
            $display("Entry at pc %h showed up after an address fault at %0t", pc0, $time);
            err_cnt++;
        end
        else if (valid0 && ((mode == POP_ALL) || ((mode == POP_RANDOM) && (r != 0))))
        begin
            pop0 = 1'b1;
            score_entry(0, ir0, pc0, plv0, excp0);
            if (valid1 && !halted && ((mode == POP_ALL) || (r >= 2)))
            begin
                pop1 = 1'b1;
                score_entry(1, ir1, pc1, plv1, excp1);
            end
        end
    endtask

    // Called just after an edge; flush wins over any pop in this cycle
    task automatic redirect_to(input addr_t target, input plv_t new_plv);
        logic bad;
        bad = (target[1:0] != 2'b00) || (target < RESET_PC) ||
              (target >= RESET_PC + addr_t'(MEM_BYTES));
        redirect    = 1'b1;
        redirect_pc = target;
        plv         = new_plv;
        pop0        = 1'b0;
        pop1        = 1'b0;
        @(posedge clk);
        #2;
        redirect = 1'b0;
        compare_flag("valid0", valid0, 1'b0);
        exp_pc        = target;
        exp_plv       = new_plv;
        fault_pending = bad;
        halted        = 1'b0;
    endtask

    task automatic wait_in_flight();
        int n;
        n = 0;
        while (!DUT.mem_req && (n < 20))
        begin
            run_cycle(POP_RANDOM);
            n++;
        end
        if (!DUT.mem_req)
        begin
            $display("No fetch request was in flight within %0d cycles at %0t", n, $time);
            err_cnt++;
        end
    endtask

    task automatic expect_halted(input string what);
        if (!halted)
        begin
            $display("No address fault entry was taken after the %s redirect", what);
            err_cnt++;
        end
    endtask

    function automatic addr_t legal_target();
        return RESET_PC + addr_t'(($urandom % 256) * 8);   // Lower half leaves room to run ahead
    endfunction

    task automatic report_test(input int num, input string name, input int errs_before,
                               input int min_pops);
        if (pop_cnt < min_pops)
        begin
            $display("Test %0d took only %0d entries, at least %0d were due",
                     num, pop_cnt, min_pops);
            err_cnt++;
        end
        if (err_cnt == errs_before)
        begin
            $display("Test %0d %s: pass, %0d entries", num, name, pop_cnt);
            tests_passed++;
        end
        else
        begin
            $display("Test %0d %s: fail, %0d errors", num, name, err_cnt - errs_before);
            tests_failed++;
        end
    endtask

    initial
    begin
        int errs0;
        void'($urandom(SEED));
        rstn          = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        plv           = 2'd0;
        pop0          = 1'b0;
        pop1          = 1'b0;
        exp_pc        = RESET_PC;
        exp_plv       = 2'd0;
        fault_pending = 1'b0;
        halted        = 1'b0;
        err_cnt       = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;

        errs0   = err_cnt;
        pop_cnt = 0;
        repeat (60) run_cycle(POP_ALL);
        report_test(1, "stream from reset", errs0, 8);

        errs0   = err_cnt;
        pop_cnt = 0;
        repeat (60) run_cycle(POP_RANDOM);
        repeat (60) run_cycle(POP_NONE);      // Fill up until fetch stalls
        compare_flag("valid1", valid1, 1'b1);
        repeat (40) run_cycle(POP_RANDOM);
        report_test(2, "random pops", errs0, 8);

        errs0   = err_cnt;
        pop_cnt = 0;
        for (int i = 0; i < 3; i++)
        begin
            wait_in_flight();
            redirect_to(legal_target(), plv);
            repeat (30) run_cycle(POP_RANDOM);
        end
        report_test(3, "redirect in flight", errs0, 8);

        errs0   = err_cnt;
        pop_cnt = 0;
        for (int i = 0; i < 2; i++)
        begin
            redirect_to(legal_target() + 32'd4, plv);
            repeat (30) run_cycle(POP_ALL);
        end
        report_test(4, "odd word target", errs0, 8);

        errs0   = err_cnt;
        pop_cnt = 0;
        redirect_to(legal_target() + addr_t'(1 + $urandom % 3), plv);
        repeat (15) run_cycle(POP_ALL);
        expect_halted("misaligned");
        redirect_to(legal_target(), plv);
        repeat (20) run_cycle(POP_ALL);
        wait_in_flight();
        redirect_to(RESET_PC + addr_t'(MEM_BYTES) + addr_t'(($urandom % 64) * 8), plv);
        repeat (15) run_cycle(POP_ALL);
        expect_halted("out of range");
        redirect_to(legal_target(), plv);
        repeat (20) run_cycle(POP_ALL);
        report_test(5, "address fault", errs0, 4);

        errs0   = err_cnt;
        pop_cnt = 0;
        redirect_to(legal_target(), 2'd3);
        repeat (30) run_cycle(POP_RANDOM);
        wait_in_flight();
        redirect_to(legal_target(), 2'd1);
        repeat (30) run_cycle(POP_ALL);
        redirect_to(RESET_PC - 32'd8, 2'd2);  // Fault entry carries the new level too
        repeat (10) run_cycle(POP_ALL);
        expect_halted("below range");
        report_test(6, "plv stamping", errs0, 8);

        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 N_TESTS, tests_passed, tests_failed, err_cnt);
        if ((tests_failed == 0) && (err_cnt == 0))
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- fetch_frontend.f
design/core_pkg.sv
design/fetch_cfg_pkg.sv
design/fetch_pc_gen.sv
design/inst_mem.sv
design/fetch_buffer.sv
design/fetch_top.sv
tb/tb_fetch_top.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f fetch_frontend.f \
    --top-module tb_fetch_top --Mdir obj_dir -o sim_fetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
